//--- source/adder_pkg.sv
// Sizes for the 64-bit add unit; the FIFO pointer logic relies on fifo_depth being a power of two
`default_nettype none

package adder_pkg;

   localparam int word_width  = 64;
   localparam int fifo_depth  = 4;
   localparam int ptr_width   = 2;  // Log2 of fifo_depth
   localparam int count_width = 3;  // Holds 0 to fifo_depth

   // Result entry layout, sum in the low word
   localparam int entry_carry_bit  = word_width;
   localparam int entry_sign_a_bit = word_width + 1;
   localparam int entry_sign_b_bit = word_width + 2;  // Sign of b after conditioning
   localparam int entry_width      = word_width + 3;

endpackage

`default_nettype wire

//--- source/op_pkg.sv
// Opcode encoding of the add unit; code 3 is unused and the operand stage treats it as add
`default_nettype none

package op_pkg;

   localparam int op_width = 2;

   typedef enum logic [op_width-1:0] {
      op_add  = 2'd0,  // Plain sum, carry-in forced low
      op_sub  = 2'd1,  // Two's complement through inverted b and carry-in high
      op_addc = 2'd2   // Sum with the external carry_in
   } alu_op_e;

endpackage

`default_nettype wire

//--- source/prefix_adder_64.sv
// Purely combinational Brent-Kung adder; the whole carry tree settles in one cycle with no pipelining
`timescale 1ns/100ps
`default_nettype none

module prefix_adder_64 import adder_pkg::*; (
   input  wire logic [word_width-1:0] a,
   input  wire logic [word_width-1:0] b,
   input  wire logic                  cin,
   output logic      [word_width-1:0] sum,
   output logic                       cout
);

   localparam int levels = 6;  // Log2 of the word width

   wire [word_width-1:0] p;
   wire [word_width-1:0] g;
   wire [word_width-1:0] up_g [0:levels];  // Group generate after each up-sweep level
   wire [word_width-1:0] up_p [0:levels];
   wire [word_width-1:0] dn_g [0:levels-1];  // Carries after each down-sweep level

   assign p = a ^ b;
   assign g = a & b;

   // Position 0 of the tree is the carry-in, so position i covers bits below i
   assign up_g[0] = {g[word_width-2:0], cin};
   assign up_p[0] = {p[word_width-2:0], 1'b0};

   for (genvar lv = 1; lv <= levels; lv++) begin : g_up
      for (genvar i = 0; i < word_width; i++) begin : g_bit
         if ((i + 1) % (1 << lv) == 0) begin : g_node
            assign up_g[lv][i] = up_g[lv-1][i] |
                                 (up_p[lv-1][i] & up_g[lv-1][i - (1 << (lv - 1))]);
            assign up_p[lv][i] = up_p[lv-1][i] & up_p[lv-1][i - (1 << (lv - 1))];
         end else begin : g_pass
            assign up_g[lv][i] = up_g[lv-1][i];
            assign up_p[lv][i] = up_p[lv-1][i];
         end
      end
   end

   // Powers of two minus one already hold full prefixes after the up-sweep
   assign dn_g[levels-1] = up_g[levels];

   for (genvar lv = levels - 1; lv >= 1; lv--) begin : g_down
      for (genvar i = 0; i < word_width; i++) begin : g_bit
         if ((i >= (1 << lv)) && ((i + 1) % (1 << lv) == (1 << (lv - 1)))) begin : g_node
            // Left neighbour is a complete prefix by now
            assign dn_g[lv-1][i] = dn_g[lv][i] |
                                   (up_p[levels][i] & dn_g[lv][i - (1 << (lv - 1))]);
         end else begin : g_pass
            assign dn_g[lv-1][i] = dn_g[lv][i];
         end
      end
   end

   assign sum  = p ^ dn_g[0];
   assign cout = g[word_width-1] | (p[word_width-1] & dn_g[0][word_width-1]);

endmodule

`default_nettype wire

//--- source/operand_stage.sv
// Requests are strobes with no handshake; a request refused for lack of space is dropped, not held
`timescale 1ns/100ps
`default_nettype none

module operand_stage import adder_pkg::*; import op_pkg::*; (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  in_strobe,
   input  wire alu_op_e               op,
   input  wire logic [word_width-1:0] a,
   input  wire logic [word_width-1:0] b,
   input  wire logic                  carry_in,
   input  wire logic                  full,
   input  wire logic                  almost_full,
   output logic                       push,
   output logic                       lost,
   output logic      [word_width-1:0] op_a,
   output logic      [word_width-1:0] op_b,
   output logic                       op_cin
);

   logic accept;

   // A pending push already owns one of the free slots
   assign accept = in_strobe && !full && !(push && almost_full);

   always_ff @(posedge clk) begin
      if (reset) begin
         push <= 1'b0;
         lost <= 1'b0;
      end else begin
         push <= accept;
         lost <= in_strobe && !accept;  // One-cycle pulse per dropped request
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_a <= a;
         case (op)
            op_sub: begin
               op_b   <= ~b;
               op_cin <= 1'b1;
            end
            op_addc: begin
               op_b   <= b;
               op_cin <= carry_in;
            end
            default: begin  // Unused code behaves as add
               op_b   <= b;
               op_cin <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/result_fifo.sv
// Four-entry FIFO with fall-through head; push when full or pop when empty is not guarded here
`timescale 1ns/100ps
`default_nettype none

module result_fifo import adder_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   push,
   input  wire logic [entry_width-1:0] wr_data,
   input  wire logic                   pop,
   output logic      [entry_width-1:0] head_data,
   output logic                        empty,
   output logic                        full,
   output logic                        almost_full
);

   logic [entry_width-1:0] mem [0:fifo_depth-1];
   logic [ptr_width-1:0]   wr_ptr;
   logic [ptr_width-1:0]   rd_ptr;
   logic [count_width-1:0] count;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither leave the fill level alone
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   assign head_data   = mem[rd_ptr];  // Oldest entry is visible without a read cycle
   assign empty       = (count == '0);
   assign full        = (count == count_width'(fifo_depth));
   assign almost_full = (count >= count_width'(fifo_depth - 1));

endmodule

`default_nettype wire

//--- source/flag_unit.sv
// A take while the FIFO is empty is ignored; outputs keep the last result until the next pop
`timescale 1ns/100ps
`default_nettype none

module flag_unit import adder_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   take,
   input  wire logic                   empty,
   input  wire logic [entry_width-1:0] head_data,
   output logic                        pop,
   output logic                        out_strobe,
   output logic      [word_width-1:0]  sum,
   output logic                        carry,
   output logic                        zero,
   output logic                        negative,
   output logic                        overflow
);

   logic [word_width-1:0] head_sum;
   logic                  sign_a;
   logic                  sign_b;

   assign pop      = take && !empty;
   assign head_sum = head_data[word_width-1:0];
   assign sign_a   = head_data[entry_sign_a_bit];
   assign sign_b   = head_data[entry_sign_b_bit];

   always_ff @(posedge clk) begin
      if (reset) begin
         out_strobe <= 1'b0;
         sum        <= '0;
         carry      <= 1'b0;
         zero       <= 1'b0;
         negative   <= 1'b0;
         overflow   <= 1'b0;
      end else begin
         out_strobe <= pop;
         if (pop) begin
            sum      <= head_sum;
            carry    <= head_data[entry_carry_bit];
            zero     <= ~|head_sum;
            negative <= head_sum[word_width-1];
            // Like-signed inputs giving an opposite-signed sum
            overflow <= (sign_a == sign_b) && (sign_a != head_sum[word_width-1]);
         end
      end
   end

endmodule

`default_nettype wire

//--- source/adder_top.sv
// Results come out in request order, one per take; a request is dropped and flagged on lost when the FIFO has no room
`timescale 1ns/100ps
`default_nettype none

module adder_top import adder_pkg::*; import op_pkg::*; (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  in_strobe,
   input  wire alu_op_e               op,
   input  wire logic [word_width-1:0] a,
   input  wire logic [word_width-1:0] b,
   input  wire logic                  carry_in,
   input  wire logic                  take,
   output logic                       lost,
   output logic                       full,
   output logic                       out_strobe,
   output logic      [word_width-1:0] sum,
   output logic                       carry,
   output logic                       zero,
   output logic                       negative,
   output logic                       overflow
);

   wire                   push;
   wire                   pop;
   wire                   empty;
   wire                   almost_full;
   wire [word_width-1:0]  op_a;
   wire [word_width-1:0]  op_b;
   wire                   op_cin;
   wire [word_width-1:0]  sum_raw;
   wire                   cout_raw;
   wire [entry_width-1:0] wr_data;
   wire [entry_width-1:0] head_data;

   operand_stage u_operand_stage (
      .clk, .reset, .in_strobe, .op, .a, .b, .carry_in, .full, .almost_full,
      .push, .lost, .op_a, .op_b, .op_cin
   );

   prefix_adder_64 u_prefix_adder (
      .a(op_a), .b(op_b), .cin(op_cin), .sum(sum_raw), .cout(cout_raw)
   );

   // Signs travel with the sum so the overflow flag can be formed at the output
   assign wr_data[word_width-1:0]  = sum_raw;
   assign wr_data[entry_carry_bit]  = cout_raw;
   assign wr_data[entry_sign_a_bit] = op_a[word_width-1];
   assign wr_data[entry_sign_b_bit] = op_b[word_width-1];

   result_fifo u_result_fifo (
      .clk, .reset, .push, .wr_data, .pop, .head_data, .empty, .full, .almost_full
   );

   flag_unit u_flag_unit (
      .clk, .reset, .take, .empty, .head_data,
      .pop, .out_strobe, .sum, .carry, .zero, .negative, .overflow
   );

endmodule

`default_nettype wire

//--- verification/adder_top_assert.sv
// Watches the result FIFO ports only; all rules are idle while reset is high
`timescale 1ns/100ps
`default_nettype none

module adder_top_assert (
   input wire logic clk,
   input wire logic reset,
   input wire logic push,
   input wire logic pop,
   input wire logic empty,
   input wire logic full
);

   int fail_count = 0;

   // The FIFO leaves overrun and underrun to its neighbours
   no_push_when_full: assert property (@(posedge clk) disable iff (reset) !(push && full))
      else begin
         fail_count++;
         $error("push while the result FIFO is full");
      end

   no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
      else begin
         fail_count++;
         $error("pop while the result FIFO is empty");
      end

   // A write without a read must leave at least one entry behind
   push_clears_empty: assert property (@(posedge clk) disable iff (reset)
                                       (push && !pop) |=> !empty)
      else begin
         fail_count++;
         $error("result FIFO still reports empty after a push");
      end

endmodule

bind result_fifo adder_top_assert u_fifo_assert (
   .clk, .reset, .push, .pop, .empty, .full
);

`default_nettype wire

//--- verification/adder_top_tb.sv
// Requests go in one at a time except in the back-pressure case; inputs change on falling edges only
`timescale 1ns/100ps
`default_nettype none

module adder_top_tb import adder_pkg::*; import op_pkg::*; ();

   localparam int num_rows   = 16;
   localparam int wait_limit = 20;  // Cycles allowed for out_strobe after a take

   typedef struct packed {
      alu_op_e               op;
      logic [word_width-1:0] a;
      logic [word_width-1:0] b;
      logic                  cin;
      logic [word_width-1:0] sum;
      logic                  carry;
      logic                  zero;
      logic                  negative;
      logic                  overflow;
   } row_t;

   logic                  clk, reset, in_strobe, carry_in, take;
   alu_op_e               op;
   logic [word_width-1:0] a, b;
   wire                   lost, full, out_strobe, carry, zero, negative, overflow;
   wire  [word_width-1:0] sum;
   row_t                  rows [0:num_rows-1];
   row_t                  queued [0:fifo_depth-1];
   int                    errors, tests, failed_tests, lost_count, errors_before;

   adder_top dut0 (
      .clk, .reset, .in_strobe, .op, .a, .b, .carry_in, .take,
      .lost, .full, .out_strobe, .sum, .carry, .zero, .negative, .overflow
   );

   always #20 clk = ~clk;

   // Reference result from 65-bit arithmetic on the unconditioned operands
   function automatic row_t model_row(alu_op_e o, logic [word_width-1:0] x,
                                      logic [word_width-1:0] y, logic c);
      logic [word_width:0] wide;
      logic                v;
      if (o == op_sub) begin
         wide = {1'b0, x} - {1'b0, y};
         wide[word_width] = (x >= y);  // Carry set means no borrow
         v = (x[word_width-1] != y[word_width-1]) && (wide[word_width-1] != x[word_width-1]);
      end else begin
         wide = {1'b0, x} + {1'b0, y} + ((o == op_addc) ? c : 1'b0);
         v = (x[word_width-1] == y[word_width-1]) && (wide[word_width-1] != x[word_width-1]);
      end
      return '{o, x, y, c, wide[word_width-1:0], wide[word_width],
               wide[word_width-1:0] == '0, wide[word_width-1], v};
   endfunction

   task automatic check_value(input string name, input logic [word_width-1:0] got,
                              input logic [word_width-1:0] expected);
      if (got !== expected) begin
         errors++;
         $display("Error: %s is %h, expected %h", name, got, expected);
      end
   endtask

   task automatic check_outputs(input row_t r);
      check_value("sum", sum, r.sum);
      check_value("carry", carry, r.carry);
      check_value("zero", zero, r.zero);
      check_value("negative", negative, r.negative);
      check_value("overflow", overflow, r.overflow);
   endtask

   task automatic take_result(output bit got_one);
      int cycles;
      got_one = 1'b0;
      cycles  = 0;
      take    = 1'b1;
      while (!got_one && cycles < wait_limit) begin
         @(negedge clk);
         got_one = out_strobe;
         cycles++;
      end
      take = 1'b0;  // Dropped on the edge that shows out_strobe, so one pop per call
   endtask

   task automatic collect_and_check(input row_t r);
      bit got_one;
      take_result(got_one);
      if (got_one) begin
         check_outputs(r);
      end else begin
         errors++;
         $display("No out_strobe within %0d cycles of take", wait_limit);
      end
   endtask

   task automatic take_while_empty();
      bit got_one;
      take_result(got_one);
      if (got_one) begin
         errors++;
         $display("out_strobe rose for a take with no stored result");
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors != errors_before) begin
         failed_tests++;
      end
      $display("Test %0d %s: %s", tests, name, (errors == errors_before) ? "pass" : "FAIL");
      errors_before = errors;
   endtask

   initial begin
      void'($urandom(32'hca7a5702));
      clk = 1'b0;
      reset = 1'b1;
      in_strobe = 1'b0;
      op = op_add;
      a = '0;
      b = '0;
      carry_in = 1'b0;
      take = 1'b0;
      errors = 0;
      tests = 0;
      failed_tests = 0;
      errors_before = 0;
      rows[0] = '{op_add, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b0, 64'h0, 1'b1, 1'b1, 1'b0, 1'b0};
      rows[1] = '{op_add, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b0,
                  64'h8000_0000_0000_0000, 1'b0, 1'b0, 1'b1, 1'b1};
      rows[2] = '{op_sub, 64'h8000_0000_0000_0000, 64'h1, 1'b0,
                  64'h7fff_ffff_ffff_ffff, 1'b1, 1'b0, 1'b0, 1'b1};
      rows[3] = '{op_sub, 64'h5, 64'h7, 1'b0, 64'hffff_ffff_ffff_fffe, 1'b0, 1'b0, 1'b1, 1'b0};
      rows[4] = '{op_sub, 64'h1234, 64'h1234, 1'b0, 64'h0, 1'b1, 1'b1, 1'b0, 1'b0};
      rows[5] = '{op_addc, 64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 64'h0, 1'b1, 1'b1, 1'b0, 1'b0};
      for (int i = 6; i < num_rows; i++) begin
         rows[i] = model_row((i < 10) ? op_addc : (($urandom % 2) ? op_sub : op_add),
                             {$urandom, $urandom}, {$urandom, $urandom}, i[0]);
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_outputs('0);
      check_value("out_strobe", out_strobe, 1'b0);
      check_value("lost", lost, 1'b0);
      take_while_empty();
      check_outputs('0);
      report_test("take after reset");

      for (int i = 0; i < num_rows; i++) begin
         op = rows[i].op;
         a = rows[i].a;
         b = rows[i].b;
         carry_in = rows[i].cin;
         in_strobe = 1'b1;
         @(negedge clk);
         in_strobe = 1'b0;
         collect_and_check(rows[i]);
         report_test($sformatf("row %0d %s", i, rows[i].op.name()));
      end

      op = op_add;
      carry_in = 1'b0;
      lost_count = 0;
      in_strobe = 1'b1;
      for (int i = 0; i <= fifo_depth; i++) begin
         a = {$urandom, $urandom};
         b = {$urandom, $urandom};
         if (i < fifo_depth) begin
            queued[i] = model_row(op_add, a, b, 1'b0);
         end
         @(negedge clk);
         lost_count += lost;
      end
      in_strobe = 1'b0;
      repeat (3) begin
         @(negedge clk);
         lost_count += lost;
      end
      check_value("lost pulses", lost_count, 1);
      check_value("full", full, 1'b1);
      for (int i = 0; i < fifo_depth; i++) begin
         collect_and_check(queued[i]);
      end
      check_value("full", full, 1'b0);
      report_test("back-pressure");
      take_while_empty();
      check_outputs(queued[fifo_depth-1]);  // Last result holds through an empty take
      report_test("take after drain");

      errors += dut0.u_result_fifo.u_fifo_assert.fail_count;
      $display("Tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
source/adder_pkg.sv
source/op_pkg.sv
source/prefix_adder_64.sv
source/operand_stage.sv
source/result_fifo.sv
source/flag_unit.sv
source/adder_top.sv
verification/adder_top_assert.sv
verification/adder_top_tb.sv

//--- Bender.yml
package:
  name: adder_top

sources:
  - files:
      - source/adder_pkg.sv
      - source/op_pkg.sv
      - source/prefix_adder_64.sv
      - source/operand_stage.sv
      - source/result_fifo.sv
      - source/flag_unit.sv
      - source/adder_top.sv
  - target: test
    files:
      - verification/adder_top_assert.sv
      - verification/adder_top_tb.sv
